/* list.f */
source/rv_isa_pkg.sv
source/fetch_pkg.sv
source/fetch_hazard_unit.sv
source/branch_predictor.sv
source/fetch_stage.sv
source/fetch_subsystem.sv
dv/fetch_checker.sv
dv/fetch_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the fetch front end testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module fetch_tb -f list.f -o fetch_sim
if [ $? -ne 0 ]; then
    echo "Compile step failed"
    exit 1
fi

./obj_dir/fetch_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Verification failed" "$LOG"; then
    exit 1
fi
if ! grep -q "Verification passed" "$LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0

/* dv/fetch_tb.sv */
/*
 * Testbench for the fetch front end; it plays the execute stage.
 * Memory returns a word computed from its address, combinationally,
 * with 0 to 3 busy cycles per transfer and an error region at 0x800.
 * Records are checked at the falling edge against a BTB mirror.
 */
module fetch_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import rv_isa_pkg::*;

    localparam word_t RESET_PC = 32'h0000_0100;
    localparam int    IDX_BITS = 3;
    localparam int    ENTRIES = 1 << IDX_BITS;
    localparam word_t FAULT_BASE = 32'h0000_0800;
    // Test lengths in records: 2, 40, 16, 20, 10
    localparam int    LIMIT = (2 + 40 + 16 + 20 + 10) * 5 + 200;

    typedef struct packed {
        word_t instr;
        logic  mal;
        logic  fault;
        logic  pred;
        word_t target;
    } exp_t;

    logic  CLK;
    logic  nRST;
    logic  imem_ren;
    word_t imem_addr;
    word_t imem_rdata;
    logic  imem_busy = 1'b0;
    logic  imem_error;
    logic  trap_redirect;
    word_t trap_pc;
    logic  ex_redirect;
    word_t ex_target;
    logic  ex_stall;
    logic  bp_update_en;
    word_t bp_update_pc;
    word_t bp_update_target;
    logic  bp_update_taken;
    logic  fx_valid;
    word_t fx_instr;
    word_t fx_pc;
    word_t fx_pc4;
    logic  fx_predicted;
    word_t fx_pred_target;
    logic  fx_mal_insn;
    logic  fx_fault_insn;

    // BTB mirror
    logic       m_valid [ENTRIES];
    word_t      m_tag [ENTRIES];
    word_t      m_target [ENTRIES];
    logic [1:0] m_count [ENTRIES];

    // Last record seen by the comparing process
    int    rec_count = 0;
    int    cmp_errors = 0;
    int    tb_errors = 0;
    int    cycles = 0;
    word_t last_pc = '0;
    word_t last_instr = '0;
    word_t last_target = '0;
    logic  last_pred = 1'b0;
    logic  last_mal = 1'b0;
    logic  last_fault = 1'b0;

    fetch_subsystem #(
        .RESET_PC      (RESET_PC),
        .BTB_INDEX_BITS(IDX_BITS)
    ) fetch_subsystem_i (.*);

    bind fetch_subsystem fetch_checker checker_i (
        .CLK(CLK), .nRST(nRST), .imem_ren(imem_ren), .imem_addr(imem_addr),
        .imem_busy(imem_busy), .trap_redirect(trap_redirect),
        .ex_redirect(ex_redirect), .ex_stall(ex_stall), .fx_valid(fx_valid),
        .fx_instr(fx_instr), .fx_mal_insn(fx_mal_insn), .fx_fault_insn(fx_fault_insn)
    );

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return (s >> 1) ^ (s[0] ? 16'hB400 : 16'h0000);
    endfunction

    function automatic word_t mem_word(input word_t a);
        word_t w;
        w = (a * 32'h9E37_79B1) ^ {a[15:0], a[31:16]};
        w[6:0] = a[4] ? BRANCH : IMMED;
        return w;
    endfunction

    function automatic logic in_fault_region(input word_t a);
        return (a >= FAULT_BASE) && (a < FAULT_BASE + 32'd64);
    endfunction

    // Expected record for a fetch at pc, using the BTB mirror
    function automatic exp_t expect_record(input word_t pc);
        exp_t                e;
        word_t               w;
        logic [IDX_BITS-1:0] idx;
        logic                hit;
        logic                ctrl;
        w = mem_word(pc);
        idx = pc[IDX_BITS+1:2];
        e.mal = (pc[1:0] != 2'b00);
        e.fault = in_fault_region(pc);
        e.instr = (e.mal || e.fault) ? '0 : w;
        hit = m_valid[idx] && (m_tag[idx] == (pc >> (IDX_BITS + 2)));
        ctrl = (w[6:0] == BRANCH) || (w[6:0] == JAL);
        e.pred = hit && m_count[idx][1] && ctrl && !e.mal && !e.fault;
        e.target = m_target[idx];
        return e;
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp,
                              output logic bad);
        bad = (got !== exp);
        if (bad) begin
            $display("Fail at %0d ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp,
                             output logic bad);
        bad = (got !== exp);
        if (bad) begin
            $display("Fail at %0d ns: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    // Memory model, busy only; data and error follow the address
    logic [15:0] mem_lfsr = 16'd34795;
    logic [1:0]  wait_left;
    assign imem_rdata = mem_word(imem_addr);
    assign imem_error = in_fault_region(imem_addr);

    always @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            imem_busy <= 1'b0;
            wait_left = 2'd0;
        end else if (!imem_busy || trap_redirect || ex_redirect) begin
            // New transfer starts next cycle
            for (int k = 0; k < 2; k++) begin
                wait_left[k] = mem_lfsr[0];
                mem_lfsr = lfsr_next(mem_lfsr);
            end
            imem_busy <= (wait_left != 2'd0);
        end else begin
            wait_left = wait_left - 2'd1;
            imem_busy <= (wait_left != 2'd0);
        end
    end

    // Comparing process
    word_t exp_next = RESET_PC;
    logic  prev_valid = 1'b0;
    word_t prev_pc = '0;
    word_t prev_instr = '0;
    logic  stall_seen = 1'b0;

    always @(negedge CLK) begin
        exp_t e;
        logic bad;
        if (nRST) begin
            // Read strobe stays up for every cycle out of reset
            check_bit("imem_ren", imem_ren, 1'b1, bad);
            cmp_errors += int'(bad);
            if (stall_seen && prev_valid) begin
                check_bit("fx_valid", fx_valid, 1'b1, bad);
                cmp_errors += int'(bad);
                check_word("fx_pc", fx_pc, prev_pc, bad);
                cmp_errors += int'(bad);
                check_word("fx_instr", fx_instr, prev_instr, bad);
                cmp_errors += int'(bad);
            end else if (fx_valid && (!prev_valid || fx_pc != prev_pc)) begin
                e = expect_record(exp_next);
                check_word("fx_pc", fx_pc, exp_next, bad);
                cmp_errors += int'(bad);
                check_word("fx_instr", fx_instr, e.instr, bad);
                cmp_errors += int'(bad);
                check_word("fx_pc4", fx_pc4, exp_next + 32'd4, bad);
                cmp_errors += int'(bad);
                check_bit("fx_mal_insn", fx_mal_insn, e.mal, bad);
                cmp_errors += int'(bad);
                check_bit("fx_fault_insn", fx_fault_insn, e.fault, bad);
                cmp_errors += int'(bad);
                check_bit("fx_predicted", fx_predicted, e.pred, bad);
                cmp_errors += int'(bad);
                if (e.pred) begin
                    check_word("fx_pred_target", fx_pred_target, e.target, bad);
                    cmp_errors += int'(bad);
                end
                exp_next = e.pred ? e.target : exp_next + 32'd4;
                rec_count++;
                last_pc = fx_pc;
                last_instr = fx_instr;
                last_pred = fx_predicted;
                last_target = fx_pred_target;
                last_mal = fx_mal_insn;
                last_fault = fx_fault_insn;
            end
            // Redirect takes effect at the coming edge
            if (trap_redirect) begin
                exp_next = trap_pc;
            end else if (ex_redirect) begin
                exp_next = ex_target;
            end
            prev_valid = fx_valid;
            prev_pc = fx_pc;
            prev_instr = fx_instr;
            stall_seen = ex_stall;
        end
    end

    always @(posedge CLK) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("Timeout: no progress within %0d cycles", LIMIT);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic wait_records(input int n);
        int target;
        target = rec_count + n;
        while (rec_count < target) begin
            @(posedge CLK);
        end
    endtask

    task automatic wait_pc(input word_t pc);
        int seen;
        logic found;
        seen = rec_count;
        found = 1'b0;
        while (!found) begin
            @(posedge CLK);
            found = (rec_count != seen) && (last_pc == pc);
            seen = rec_count;
        end
    endtask

    task automatic pulse_redirect(input logic trap, input word_t tpc,
                                  input logic ex, input word_t tgt);
        @(posedge CLK);
        trap_redirect <= trap;
        trap_pc <= tpc;
        ex_redirect <= ex;
        ex_target <= tgt;
        @(posedge CLK);
        trap_redirect <= 1'b0;
        ex_redirect <= 1'b0;
    endtask

    // One training update while the pipe is stalled, mirrored after the write
    task automatic train(input word_t pc, input word_t tgt, input logic taken);
        logic [IDX_BITS-1:0] idx;
        logic                hit;
        idx = pc[IDX_BITS+1:2];
        hit = m_valid[idx] && (m_tag[idx] == (pc >> (IDX_BITS + 2)));
        @(posedge CLK);
        bp_update_en <= 1'b1;
        bp_update_pc <= pc;
        bp_update_target <= tgt;
        bp_update_taken <= taken;
        @(posedge CLK);
        bp_update_en <= 1'b0;
        if (!hit) begin
            m_count[idx] = taken ? 2'd2 : 2'd1;
        end else if (taken && m_count[idx] != 2'd3) begin
            m_count[idx] = m_count[idx] + 2'd1;
        end else if (!taken && m_count[idx] != 2'd0) begin
            m_count[idx] = m_count[idx] - 2'd1;
        end
        m_valid[idx] = 1'b1;
        m_tag[idx] = pc >> (IDX_BITS + 2);
        m_target[idx] = tgt;
    endtask

    task automatic report_test(input string name, inout int errs_before);
        int now;
        now = tb_errors + cmp_errors;
        $display("Test %s done with %0d errors", name, now - errs_before);
        errs_before = now;
    endtask

    initial begin
        logic [15:0] stim_lfsr;
        logic [2:0]  bits;
        logic        bad;
        int          errs;
        int          target;
        stim_lfsr = 16'd34795;
        errs = 0;
        nRST = 1'b0;
        trap_redirect = 1'b0;
        trap_pc = '0;
        ex_redirect = 1'b0;
        ex_target = '0;
        ex_stall = 1'b0;
        bp_update_en = 1'b0;
        bp_update_pc = '0;
        bp_update_target = '0;
        bp_update_taken = 1'b0;
        for (int i = 0; i < ENTRIES; i++) begin
            m_valid[i] = 1'b0;
            m_count[i] = 2'd1;
            m_tag[i] = '0;
            m_target[i] = '0;
        end
        repeat (5) @(posedge CLK);
        nRST <= 1'b1;

        // Reset state and first record
        @(negedge CLK);
        check_bit("fx_valid", fx_valid, 1'b0, bad);
        tb_errors += int'(bad);
        wait_records(1);
        check_word("fx_pc", last_pc, RESET_PC, bad);
        tb_errors += int'(bad);
        wait_records(1);
        report_test("reset", errs);

        // Sequential fetch with random ex_stall
        target = rec_count + 40;
        while (rec_count < target) begin
            @(posedge CLK);
            for (int k = 0; k < 3; k++) begin
                bits[k] = stim_lfsr[0];
                stim_lfsr = lfsr_next(stim_lfsr);
            end
            ex_stall <= (bits == 3'b111);
        end
        ex_stall <= 1'b0;
        report_test("sequential", errs);

        // Redirects, trap over execute
        pulse_redirect(1'b0, '0, 1'b1, 32'h0000_0500);
        wait_pc(32'h0000_0500);
        wait_records(3);
        pulse_redirect(1'b1, 32'h0000_0600, 1'b0, '0);
        wait_pc(32'h0000_0600);
        wait_records(3);
        pulse_redirect(1'b1, 32'h0000_0680, 1'b1, 32'h0000_0700);
        wait_records(1);
        check_word("fx_pc", last_pc, 32'h0000_0680, bad);
        tb_errors += int'(bad);
        wait_records(3);
        report_test("redirect", errs);

        // BTB training under stall
        @(posedge CLK);
        ex_stall <= 1'b1;
        train(32'h0000_0210, 32'h0000_0400, 1'b1);
        train(32'h0000_0210, 32'h0000_0400, 1'b1);
        train(32'h0000_0214, 32'h0000_0480, 1'b0);
        train(32'h0000_0214, 32'h0000_0480, 1'b0);
        train(32'h0000_0228, 32'h0000_04C0, 1'b1);
        train(32'h0000_0228, 32'h0000_04C0, 1'b1);
        @(posedge CLK);
        ex_stall <= 1'b0;
        pulse_redirect(1'b0, '0, 1'b1, 32'h0000_0200);
        wait_pc(32'h0000_0210);
        check_bit("fx_predicted", last_pred, 1'b1, bad);
        tb_errors += int'(bad);
        check_word("fx_pred_target", last_target, 32'h0000_0400, bad);
        tb_errors += int'(bad);
        wait_records(1);
        check_word("fx_pc", last_pc, 32'h0000_0400, bad);
        tb_errors += int'(bad);
        pulse_redirect(1'b0, '0, 1'b1, 32'h0000_0214);
        wait_pc(32'h0000_0214);
        check_bit("fx_predicted", last_pred, 1'b0, bad);
        tb_errors += int'(bad);
        pulse_redirect(1'b0, '0, 1'b1, 32'h0000_0228);
        wait_pc(32'h0000_0228);
        check_bit("fx_predicted", last_pred, 1'b0, bad);
        tb_errors += int'(bad);
        wait_records(2);
        report_test("predictor", errs);

        // Misaligned target, then the error region
        pulse_redirect(1'b0, '0, 1'b1, 32'h0000_0302);
        wait_pc(32'h0000_0302);
        check_bit("fx_mal_insn", last_mal, 1'b1, bad);
        tb_errors += int'(bad);
        check_word("fx_instr", last_instr, '0, bad);
        tb_errors += int'(bad);
        pulse_redirect(1'b0, '0, 1'b1, 32'h0000_07F8);
        wait_pc(32'h0000_0800);
        check_bit("fx_fault_insn", last_fault, 1'b1, bad);
        tb_errors += int'(bad);
        check_word("fx_instr", last_instr, '0, bad);
        tb_errors += int'(bad);
        wait_records(2);
        report_test("exceptions", errs);

        $display("Tests 5, records %0d, errors %0d", rec_count, tb_errors + cmp_errors);
        if (tb_errors + cmp_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* dv/fetch_checker.sv */
/*
 * Protocol assertions for the fetch front end, bound into the top level.
 * Checks are disabled while nRST is low.
 * A redirect is allowed to move the bus address during a wait.
 */
module fetch_checker (
    input logic              CLK,
    input logic              nRST,
    input logic              imem_ren,
    input rv_isa_pkg::word_t imem_addr,
    input logic              imem_busy,
    input logic              trap_redirect,
    input logic              ex_redirect,
    input logic              ex_stall,
    input logic              fx_valid,
    input rv_isa_pkg::word_t fx_instr,
    input logic              fx_mal_insn,
    input logic              fx_fault_insn
);
    timeunit 1ns;
    timeprecision 1ps;
    import fetch_pkg::*;

    redirect_t redir_src;

    // Trap wins over execute, prediction is not visible here
    always_comb begin
        if (trap_redirect) begin
            redir_src = REDIR_TRAP;
        end else if (ex_redirect) begin
            redir_src = REDIR_EXEC;
        end else begin
            redir_src = REDIR_NONE;
        end
    end

    addr_hold: assert property (@(posedge CLK) disable iff (!nRST)
        imem_ren && imem_busy && (redir_src == REDIR_NONE) |=> $stable(imem_addr))
        else $error("imem_addr moved during a bus wait");

    flush_clears: assert property (@(posedge CLK) disable iff (!nRST)
        (redir_src != REDIR_NONE) && !ex_stall |=> !fx_valid)
        else $error("record still valid after a redirect");

    squash_instr: assert property (@(posedge CLK) disable iff (!nRST)
        (fx_mal_insn || fx_fault_insn) |-> (fx_instr == '0))
        else $error("exception record carries an instruction");

endmodule

/* source/fetch_subsystem.sv */
/*
 * Fetch front end top level.
 * Connects the fetch stage, the BTB and the hazard unit.
 * The execute stage lives outside: it drives the redirect pulses,
 * the stall level and the BTB training port, and takes the fx record.
 */
module fetch_subsystem #(
    parameter rv_isa_pkg::word_t RESET_PC       = 32'h0000_0100,
    parameter int                BTB_INDEX_BITS = 3
) (
    input  logic              CLK,
    input  logic              nRST,
    // Instruction bus
    output logic              imem_ren,
    output rv_isa_pkg::word_t imem_addr,
    input  rv_isa_pkg::word_t imem_rdata,
    input  logic              imem_busy,
    input  logic              imem_error,
    // Redirects and stall from execute
    input  logic              trap_redirect,
    input  rv_isa_pkg::word_t trap_pc,
    input  logic              ex_redirect,
    input  rv_isa_pkg::word_t ex_target,
    input  logic              ex_stall,
    // BTB training
    input  logic              bp_update_en,
    input  rv_isa_pkg::word_t bp_update_pc,
    input  rv_isa_pkg::word_t bp_update_target,
    input  logic              bp_update_taken,
    // Record to execute
    output logic              fx_valid,
    output rv_isa_pkg::word_t fx_instr,
    output rv_isa_pkg::word_t fx_pc,
    output rv_isa_pkg::word_t fx_pc4,
    output logic              fx_predicted,
    output rv_isa_pkg::word_t fx_pred_target,
    output logic              fx_mal_insn,
    output logic              fx_fault_insn
);
    import rv_isa_pkg::*;

    logic  pc_en;
    logic  iren;
    logic  if_ex_stall;
    logic  if_ex_flush;
    logic  i_mem_busy;
    word_t lookup_pc;
    word_t lookup_instr;
    logic  predict_taken;
    word_t predict_target;

    fetch_hazard_unit hazard_i (
        .i_mem_busy   (i_mem_busy),
        .ex_stall     (ex_stall),
        .trap_redirect(trap_redirect),
        .ex_redirect  (ex_redirect),
        .pc_en        (pc_en),
        .iren         (iren),
        .if_ex_stall  (if_ex_stall),
        .if_ex_flush  (if_ex_flush)
    );

    branch_predictor #(
        .BTB_INDEX_BITS(BTB_INDEX_BITS)
    ) predictor_i (
        .CLK           (CLK),
        .nRST          (nRST),
        .lookup_pc     (lookup_pc),
        .lookup_instr  (lookup_instr),
        .update_en     (bp_update_en),
        .update_pc     (bp_update_pc),
        .update_target (bp_update_target),
        .update_taken  (bp_update_taken),
        .predict_taken (predict_taken),
        .predict_target(predict_target)
    );

    fetch_stage #(
        .RESET_PC(RESET_PC)
    ) fetch_i (
        .CLK           (CLK),
        .nRST          (nRST),
        .pc_en         (pc_en),
        .iren          (iren),
        .if_ex_stall   (if_ex_stall),
        .if_ex_flush   (if_ex_flush),
        .trap_redirect (trap_redirect),
        .trap_pc       (trap_pc),
        .ex_redirect   (ex_redirect),
        .ex_target     (ex_target),
        .predict_taken (predict_taken),
        .predict_target(predict_target),
        .imem_rdata    (imem_rdata),
        .imem_busy     (imem_busy),
        .imem_error    (imem_error),
        .i_mem_busy    (i_mem_busy),
        .lookup_pc     (lookup_pc),
        .lookup_instr  (lookup_instr),
        .imem_ren      (imem_ren),
        .imem_addr     (imem_addr),
        .fx_valid      (fx_valid),
        .fx_instr      (fx_instr),
        .fx_pc         (fx_pc),
        .fx_pc4        (fx_pc4),
        .fx_predicted  (fx_predicted),
        .fx_pred_target(fx_pred_target),
        .fx_mal_insn   (fx_mal_insn),
        .fx_fault_insn (fx_fault_insn)
    );

endmodule

/* source/fetch_stage.sv */
/*
 * Fetch stage: PC register, next-PC select, instruction bus request
 * and the fetch/execute record.
 * Next PC priority is trap, execute redirect, prediction, then PC+4.
 * Only word-aligned fetches are legal; a misaligned PC or a bus error
 * gives a valid record with the instruction squashed to zero.
 * No prediction is followed for a fetch that raised an exception.
 */
module fetch_stage #(
    parameter rv_isa_pkg::word_t RESET_PC = 32'h0000_0100
) (
    input  logic              CLK,
    input  logic              nRST,
    input  logic              pc_en,
    input  logic              iren,
    input  logic              if_ex_stall,
    input  logic              if_ex_flush,
    input  logic              trap_redirect,
    input  rv_isa_pkg::word_t trap_pc,
    input  logic              ex_redirect,
    input  rv_isa_pkg::word_t ex_target,
    input  logic              predict_taken,
    input  rv_isa_pkg::word_t predict_target,
    input  rv_isa_pkg::word_t imem_rdata,
    input  logic              imem_busy,
    input  logic              imem_error,
    output logic              i_mem_busy,
    output rv_isa_pkg::word_t lookup_pc,
    output rv_isa_pkg::word_t lookup_instr,
    output logic              imem_ren,
    output rv_isa_pkg::word_t imem_addr,
    output logic              fx_valid,
    output rv_isa_pkg::word_t fx_instr,
    output rv_isa_pkg::word_t fx_pc,
    output rv_isa_pkg::word_t fx_pc4,
    output logic              fx_predicted,
    output rv_isa_pkg::word_t fx_pred_target,
    output logic              fx_mal_insn,
    output logic              fx_fault_insn
);
    import rv_isa_pkg::*;
    import fetch_pkg::*;

    word_t     pc;
    word_t     pc4;
    word_t     npc;
    redirect_t next_sel;
    logic      mal_insn;
    logic      fault_insn;
    logic      use_predict;
    fetch_ex_t fx_reg;

    // PC register
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            pc <= RESET_PC;
        end else if (pc_en) begin
            pc <= npc;
        end
    end

    assign pc4 = pc + 32'd4;

    // Exceptions for the current fetch
    assign mal_insn    = (pc[1:0] != 2'b00);
    assign fault_insn  = imem_ren && !imem_busy && imem_error;
    assign use_predict = predict_taken && !mal_insn && !fault_insn;

    // Next-PC source, highest priority first
    always_comb begin
        if (trap_redirect) begin
            next_sel = REDIR_TRAP;
        end else if (ex_redirect) begin
            next_sel = REDIR_EXEC;
        end else if (use_predict) begin
            next_sel = REDIR_PREDICT;
        end else begin
            next_sel = REDIR_NONE;
        end
    end

    always_comb begin
        case (next_sel)
            REDIR_TRAP:    npc = trap_pc;
            REDIR_EXEC:    npc = ex_target;
            REDIR_PREDICT: npc = predict_target;
            default:       npc = pc4;
        endcase
    end

    // Instruction bus, read only, address is the PC itself
    assign imem_ren   = iren;
    assign imem_addr  = pc;
    assign i_mem_busy = imem_busy;

    // Predictor sees the word as it arrives
    assign lookup_pc    = pc;
    assign lookup_instr = imem_rdata;

    // Fetch/execute record
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            fx_reg <= '0;
        end else if (!if_ex_stall) begin
            if (if_ex_flush) begin
                fx_reg <= '0;
            end else begin
                fx_reg.valid       <= 1'b1;
                // Squashed to zero on an exception but kept valid for the trap
                fx_reg.instr       <= (mal_insn || fault_insn) ? '0 : imem_rdata;
                fx_reg.pc          <= pc;
                fx_reg.pc4         <= pc4;
                fx_reg.predicted   <= use_predict;
                fx_reg.pred_target <= predict_target;
                fx_reg.mal_insn    <= mal_insn;
                fx_reg.fault_insn  <= fault_insn;
            end
        end
    end

    assign fx_valid       = fx_reg.valid;
    assign fx_instr       = fx_reg.instr;
    assign fx_pc          = fx_reg.pc;
    assign fx_pc4         = fx_reg.pc4;
    assign fx_predicted   = fx_reg.predicted;
    assign fx_pred_target = fx_reg.pred_target;
    assign fx_mal_insn    = fx_reg.mal_insn;
    assign fx_fault_insn  = fx_reg.fault_insn;

endmodule

/* source/branch_predictor.sv */
/*
 * Direct-mapped branch target buffer with 2-bit saturating counters.
 * Lookup is combinational; updates land at the clock edge.
 * Predicts only when the looked-up word is a BRANCH or JAL.
 * Entries are indexed by PC[BTB_INDEX_BITS+1:2] and tagged with the
 * remaining upper PC bits.
 */
module branch_predictor #(
    parameter int BTB_INDEX_BITS = 3
) (
    input  logic              CLK,
    input  logic              nRST,
    input  rv_isa_pkg::word_t lookup_pc,
    input  rv_isa_pkg::word_t lookup_instr,
    input  logic              update_en,
    input  rv_isa_pkg::word_t update_pc,
    input  rv_isa_pkg::word_t update_target,
    input  logic              update_taken,
    output logic              predict_taken,
    output rv_isa_pkg::word_t predict_target
);
    import rv_isa_pkg::*;

    localparam int ENTRIES = 1 << BTB_INDEX_BITS;
    localparam int TAG_BITS = 32 - BTB_INDEX_BITS - 2;

    logic                      btb_valid [ENTRIES];
    logic [1:0]                btb_count [ENTRIES];
    logic [TAG_BITS-1:0]       btb_tag [ENTRIES];
    word_t                     btb_target [ENTRIES];

    logic [BTB_INDEX_BITS-1:0] lk_idx;
    logic [TAG_BITS-1:0]       lk_tag;
    logic                      lk_hit;
    logic                      lk_ctrl;
    sbtype_t                   lk_fields;

    logic [BTB_INDEX_BITS-1:0] up_idx;
    logic [TAG_BITS-1:0]       up_tag;
    logic                      up_hit;

    // Lookup side
    assign lk_idx    = lookup_pc[BTB_INDEX_BITS+1:2];
    assign lk_tag    = lookup_pc[31:BTB_INDEX_BITS+2];
    assign lk_hit    = btb_valid[lk_idx] && (btb_tag[lk_idx] == lk_tag);
    assign lk_fields = sbtype_t'(lookup_instr);
    assign lk_ctrl   = (lk_fields.opcode == BRANCH) || (lk_fields.opcode == JAL);

    // Counter MSB set means 2 or 3
    assign predict_taken  = lk_hit && btb_count[lk_idx][1] && lk_ctrl;
    assign predict_target = btb_target[lk_idx];

    // Update side
    assign up_idx = update_pc[BTB_INDEX_BITS+1:2];
    assign up_tag = update_pc[31:BTB_INDEX_BITS+2];
    assign up_hit = btb_valid[up_idx] && (btb_tag[up_idx] == up_tag);

    // Valid bits and counters
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < ENTRIES; i++) begin
                btb_valid[i] <= 1'b0;
                btb_count[i] <= 2'd1;
            end
        end else if (update_en) begin
            btb_valid[up_idx] <= 1'b1;
            if (!up_hit) begin
                // Fresh entry starts weakly biased toward the outcome
                btb_count[up_idx] <= update_taken ? 2'd2 : 2'd1;
            end else if (update_taken && btb_count[up_idx] != 2'd3) begin
                btb_count[up_idx] <= btb_count[up_idx] + 2'd1;
            end else if (!update_taken && btb_count[up_idx] != 2'd0) begin
                btb_count[up_idx] <= btb_count[up_idx] - 2'd1;
            end
        end
    end

    // Tags and targets
    always_ff @(posedge CLK) begin
        if (update_en) begin
            btb_tag[up_idx]    <= up_tag;
            btb_target[up_idx] <= update_target;
        end
    end

endmodule

/* source/fetch_hazard_unit.sv */
/*
 * Hazard control for the fetch stage.
 * Purely combinational. Redirects are expected as single-cycle pulses.
 * A redirect overrides a pending bus wait, so the record is flushed and
 * the fetch restarts at the new PC. A downstream stall still holds the
 * record, while the PC moves to the redirect target.
 */
module fetch_hazard_unit (
    input  logic i_mem_busy,
    input  logic ex_stall,
    input  logic trap_redirect,
    input  logic ex_redirect,
    output logic pc_en,
    output logic iren,
    output logic if_ex_stall,
    output logic if_ex_flush
);

    logic redirect;
    logic hold;

    // Any change of flow from the execute side
    assign redirect = trap_redirect | ex_redirect;

    // Fetch cannot advance while waiting on memory or execute
    assign hold = ex_stall | i_mem_busy;

    // Record is cleared on every redirect
    assign if_ex_flush = redirect;

    // Busy gives way to a redirect, ex_stall never does
    assign if_ex_stall = ex_stall | (i_mem_busy & ~redirect);

    // PC follows a redirect even when the pipe is held
    assign pc_en = ~hold | redirect;

    // No read suppression in this core
    // The request stays up for every cycle after reset release
    assign iren = 1'b1;

endmodule

/* source/fetch_pkg.sv */
/*
 * Fetch front end definitions.
 * The fetch/execute record is a plain packed struct, with no
 * compressed-instruction or bad-address fields.
 */
package fetch_pkg;

    // Source of the next PC, in priority order
    typedef enum logic [1:0] {
        REDIR_NONE,
        REDIR_TRAP,
        REDIR_EXEC,
        REDIR_PREDICT
    } redirect_t;

    // Fetch/execute pipeline record
    typedef struct packed {
        logic               valid;
        rv_isa_pkg::word_t  instr;
        rv_isa_pkg::word_t  pc;
        rv_isa_pkg::word_t  pc4;
        logic               predicted;
        rv_isa_pkg::word_t  pred_target;
        logic               mal_insn;
        logic               fault_insn;
    } fetch_ex_t;

endpackage

/* source/rv_isa_pkg.sv */
/*
 * RV32I base definitions shared by the fetch front end.
 * Only the 32-bit uncompressed encoding is described here.
 * Opcode values are the 7-bit major opcodes of the base ISA.
 */
package rv_isa_pkg;

    // Data and address word
    typedef logic [31:0] word_t;

    // Major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        IMMED  = 7'b0010011,
        REG    = 7'b0110011,
        SYSTEM = 7'b1110011
    } opcode_t;

    // B-type field layout, MSB first
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_05;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm04_01;
        logic       imm11;
        opcode_t    opcode;
    } sbtype_t;

endpackage
